/* dv/ahb_spi_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_spi_chk (
    input logic hclk,
    input logic hresetn,
    input logic hreadyout_i,
    input logic hresp_i,
    input logic spi_clk_i,
    input logic cpol_i,
    input logic busy_i,
    input logic tx_wen_i,
    input logic tx_full_i,
    input logic tx_ren_i,
    input logic tx_empty_i,
    input logic rx_wen_i,
    input logic rx_full_i,
    input logic rx_ren_i,
    input logic rx_empty_i
);
    a_no_error_resp: assert property (@(posedge hclk) disable iff (!hresetn) !hresp_i)
        else $error("hresp_o went high, error responses are not used");

    a_ready_after_reset: assert property (@(posedge hclk) $rose(hresetn) |-> hreadyout_i)
        else $error("hreadyout_o low in the first cycle after reset");

    // clock rests at cpol between frames
    a_idle_clk: assert property (@(posedge hclk) disable iff (!hresetn)
        !busy_i |-> (spi_clk_i == cpol_i))
        else $error("spi_clk_o differs from cpol while the engine is idle");

    a_tx_push_full: assert property (@(posedge hclk) disable iff (!hresetn)
        !(tx_wen_i && tx_full_i))
        else $error("push into a full tx fifo");

    a_tx_pop_empty: assert property (@(posedge hclk) disable iff (!hresetn)
        !(tx_ren_i && tx_empty_i))
        else $error("pop from an empty tx fifo");

    a_rx_push_full: assert property (@(posedge hclk) disable iff (!hresetn)
        !(rx_wen_i && rx_full_i))
        else $error("push into a full rx fifo");

    a_rx_pop_empty: assert property (@(posedge hclk) disable iff (!hresetn)
        !(rx_ren_i && rx_empty_i))
        else $error("pop from an empty rx fifo");

endmodule

`default_nettype wire

/* dv/tb_ahb_spi.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_macros.svh"

module tb_ahb_spi;
    localparam int BUS_TIMEOUT = 1000;  // in cycles and far above the longest frame
    localparam logic [`AHB_AWIDTH-1:0] ADDR_DATA = {{(`AHB_AWIDTH-4){1'b0}}, `SPI_REG_DATA};
    localparam logic [`AHB_AWIDTH-1:0] ADDR_CTRL = {{(`AHB_AWIDTH-4){1'b0}}, `SPI_REG_CTRL};

    logic                   hclk = 1'b0;
    logic                   hresetn = 1'b0;
    logic                   hsel_i = 1'b0;
    logic                   hwrite_i = 1'b0;
    logic                   hready_i = 1'b1;
    logic [2:0]             hsize_i = 3'b010;
    logic [2:0]             hburst_i = 3'b000;
    logic [1:0]             htrans_i = 2'b00;
    logic [`AHB_AWIDTH-1:0] haddr_i = '0;
    logic [`AHB_DWIDTH-1:0] hwdata_i = '0;
    logic                   hreadyout_o;
    logic                   hresp_o;
    logic [`AHB_DWIDTH-1:0] hrdata_o;
    logic                   spi_miso_i = 1'b0;
    logic                   spi_clk_o;
    logic                   spi_mosi_o;
    logic [1:0]             spi_nss_o;

    int         seed = 475;
    logic [7:0] exp_q [$];  // bytes in flight in send order

    ahb_spi i_dut (.*);

    bind ahb_spi ahb_spi_chk u_chk (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hreadyout_i (hreadyout_o),
        .hresp_i     (hresp_o),
        .spi_clk_i   (spi_clk_o),
        .cpol_i      (ctrl.f.cpol),
        .busy_i      (u_engine.busy),
        .tx_wen_i    (tx_q.wen),
        .tx_full_i   (tx_q.full),
        .tx_ren_i    (tx_q.ren),
        .tx_empty_i  (tx_q.empty),
        .rx_wen_i    (rx_q.wen),
        .rx_full_i   (rx_q.full),
        .rx_ren_i    (rx_q.ren),
        .rx_empty_i  (rx_q.empty)
    );

    initial begin
        forever #20 hclk = ~hclk;
    end

    always @(negedge hclk) begin
        hready_i   <= hreadyout_o;  // single slave on the bus
        spi_miso_i <= spi_mosi_o;   // loopback
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    function automatic logic [7:0] rand_byte();
        int rnd;
        rnd = $random(seed);
        return rnd[7:0];
    endfunction

    function automatic logic [7:0] make_ctrl(input logic [2:0] div, input logic [1:0] nss,
                                             input logic cpha, input logic cpol,
                                             input logic en);
        return {div, nss, cpha, cpol, en};
    endfunction

    task automatic ahb_write(input logic [`AHB_AWIDTH-1:0] addr,
                             input logic [`AHB_DWIDTH-1:0] data, output int waits);
        int cnt;
        @(negedge hclk);
        hsel_i   = 1'b1;
        hwrite_i = 1'b1;
        htrans_i = 2'b10;  // nonseq
        haddr_i  = addr;
        @(negedge hclk);
        hsel_i   = 1'b0;
        htrans_i = 2'b00;
        hwdata_i = data;
        cnt = 0;
        while (!hreadyout_o) begin
            if (cnt >= BUS_TIMEOUT) begin
                abort_run($sformatf("timeout: write to %h never got hreadyout", addr));
            end
            @(negedge hclk);
            cnt++;
        end
        waits = cnt;
    endtask

    task automatic ahb_read(input logic [`AHB_AWIDTH-1:0] addr,
                            output logic [`AHB_DWIDTH-1:0] data, output int waits);
        int cnt;
        @(negedge hclk);
        hsel_i   = 1'b1;
        hwrite_i = 1'b0;
        htrans_i = 2'b10;
        haddr_i  = addr;
        @(negedge hclk);
        hsel_i   = 1'b0;
        htrans_i = 2'b00;
        cnt = 0;
        while (!hreadyout_o) begin
            if (cnt >= BUS_TIMEOUT) begin
                abort_run($sformatf("timeout: read of %h never got hreadyout", addr));
            end
            @(negedge hclk);
            cnt++;
        end
        data  = hrdata_o;  // completes on the next rising edge
        waits = cnt;
    endtask

    // ctrl takes effect on the edge after the data phase
    task automatic set_ctrl(input logic [7:0] val);
        logic [1:0] exp_nss;
        int         waits;
        ahb_write(ADDR_CTRL, {24'h0, val}, waits);
        check_value("ctrl write without wait", 32'd0, waits);
        @(negedge hclk);
        exp_nss = val[0] ? val[4:3] : 2'b11;
        check_value("slave select", {30'h0, exp_nss}, {30'h0, spi_nss_o});
    endtask

    task automatic send_byte(output int waits);
        logic [7:0] b;
        b = rand_byte();
        exp_q.push_back(b);
        ahb_write(ADDR_DATA, {24'h0, b}, waits);
    endtask

    task automatic drain_bytes(input int count, input string name);
        logic [31:0] rd;
        logic [7:0]  exp_b;
        int          waits;
        int          k;
        for (k = 0; k < count; k++) begin
            ahb_read(ADDR_DATA, rd, waits);
            exp_b = exp_q.pop_front();
            check_value(name, {24'h0, exp_b}, rd);
        end
    endtask

    task automatic ctrl_readback();
        logic [7:0]  val;
        logic [31:0] rd;
        int          waits;
        int          i;
        for (i = 0; i < 10; i++) begin
            val    = rand_byte();
            val[0] = i[0];  // en alternates
            set_ctrl(val);
            ahb_read(ADDR_CTRL, rd, waits);
            check_value("ctrl readback", {24'h0, val}, rd);
        end
        ahb_read(32'h8, rd, waits);
        check_value("undefined offset read", 32'h0, rd);
    endtask

    task automatic loopback_all_modes();
        logic [2:0] div;
        int         waits;
        int         mode;
        int         d;
        int         k;
        for (mode = 0; mode < 4; mode++) begin
            for (d = 0; d < 2; d++) begin
                div = (d == 0) ? 3'd0 : 3'd3;
                set_ctrl(make_ctrl(div, 2'b01, mode[1], mode[0], 1'b1));
                for (k = 0; k < 4; k++) begin
                    send_byte(waits);
                end
                drain_bytes(4, $sformatf("loopback cpha %0d cpol %0d div %0d",
                                         mode[1], mode[0], div));
            end
        end
    endtask

    task automatic read_stall();
        logic [31:0] rd;
        logic [7:0]  exp_b;
        int          waits;
        set_ctrl(make_ctrl(3'd0, 2'b10, 1'b0, 1'b0, 1'b1));
        send_byte(waits);
        ahb_read(ADDR_DATA, rd, waits);  // rx still empty here
        check_value("read wait stalled", 32'd1, {31'h0, (waits > 0)});
        exp_b = exp_q.pop_front();
        check_value("read wait data", {24'h0, exp_b}, rd);
    endtask

    task automatic write_backpressure();
        int waits;
        int k;
        set_ctrl(make_ctrl(3'd7, 2'b00, 1'b0, 1'b0, 1'b0));
        for (k = 0; k < `SPI_FIFO_DEPTH; k++) begin
            send_byte(waits);
            check_value("fill without wait", 32'd0, waits);
        end
        set_ctrl(make_ctrl(3'd7, 2'b00, 1'b0, 1'b0, 1'b1));
        send_byte(waits);  // takes the slot of the first popped byte
        send_byte(waits);
        check_value("write stalled on full fifo", 32'd1, {31'h0, (waits > 0)});
        drain_bytes(`SPI_FIFO_DEPTH + 2, "back-pressure readback");
    endtask

    initial begin
        repeat (3) @(negedge hclk);
        hresetn = 1'b1;
        ctrl_readback();
        loopback_all_modes();
        read_stall();
        write_backpressure();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ahb_spi.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_macros.svh"

module ahb_spi
    import spi_pkg::*;
(
    input  logic                   hclk,
    input  logic                   hresetn,

    input  logic                   hsel_i,
    input  logic                   hwrite_i,
    input  logic                   hready_i,
    input  logic [2:0]             hsize_i,
    input  logic [2:0]             hburst_i,
    input  logic [1:0]             htrans_i,
    input  logic [`AHB_AWIDTH-1:0] haddr_i,
    input  logic [`AHB_DWIDTH-1:0] hwdata_i,

    output logic                   hreadyout_o,
    output logic                   hresp_o,
    output logic [`AHB_DWIDTH-1:0] hrdata_o,

    input  logic                   spi_miso_i,
    output logic                   spi_clk_o,
    output logic                   spi_mosi_o,
    output logic [1:0]             spi_nss_o
);
    spi_ctrl_u ctrl;

    byte_fifo_if tx_q ();  // bus to engine
    byte_fifo_if rx_q ();  // engine to bus

    ahb_spi_regs u_regs (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hsel_i      (hsel_i),
        .hwrite_i    (hwrite_i),
        .hready_i    (hready_i),
        .hsize_i     (hsize_i),
        .hburst_i    (hburst_i),
        .htrans_i    (htrans_i),
        .haddr_i     (haddr_i),
        .hwdata_i    (hwdata_i),
        .hreadyout_o (hreadyout_o),
        .hresp_o     (hresp_o),
        .hrdata_o    (hrdata_o),
        .tx_q        (tx_q.producer),
        .rx_q        (rx_q.consumer),
        .ctrl_o      (ctrl)
    );

    sync_fifo #(.DEPTH(`SPI_FIFO_DEPTH), .DWIDTH(8)) u_tx_fifo (
        .hclk    (hclk),
        .hresetn (hresetn),
        .q       (tx_q.fifo)
    );

    sync_fifo #(.DEPTH(`SPI_FIFO_DEPTH), .DWIDTH(8)) u_rx_fifo (
        .hclk    (hclk),
        .hresetn (hresetn),
        .q       (rx_q.fifo)
    );

    spi_shift_engine u_engine (
        .hclk       (hclk),
        .hresetn    (hresetn),
        .ctrl_i     (ctrl),
        .tx_q       (tx_q.consumer),
        .rx_q       (rx_q.producer),
        .spi_miso_i (spi_miso_i),
        .spi_clk_o  (spi_clk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_nss_o  (spi_nss_o)
    );

endmodule

`default_nettype wire

/* hdl/ahb_spi_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_macros.svh"

module ahb_spi_regs
    import spi_pkg::*;
(
    input  logic                   hclk,
    input  logic                   hresetn,

    input  logic                   hsel_i,
    input  logic                   hwrite_i,
    input  logic                   hready_i,
    input  logic [2:0]             hsize_i,
    input  logic [2:0]             hburst_i,
    input  logic [1:0]             htrans_i,
    input  logic [`AHB_AWIDTH-1:0] haddr_i,
    input  logic [`AHB_DWIDTH-1:0] hwdata_i,

    output logic                   hreadyout_o,
    output logic                   hresp_o,
    output logic [`AHB_DWIDTH-1:0] hrdata_o,

    byte_fifo_if.producer          tx_q,
    byte_fifo_if.consumer          rx_q,
    output spi_ctrl_u              ctrl_o
);
    typedef enum logic [1:0] {
        PREPARE,
        WAIT_READ,
        WAIT_WRITE
    } state_e;

    state_e    state;
    state_e    next_state;
    spi_ctrl_u ctrl;

    logic       sel_ok;
    logic       ph_valid;
    logic       ph_write;
    logic [3:0] ph_addr;

    logic data_rd;
    logic data_wr;
    logic ctrl_rd;
    logic ctrl_wr;

    // only single nonseq transfers up to word size
    assign sel_ok = hsel_i
                 && (htrans_e'(htrans_i) == HTRANS_NONSEQ)
                 && (hburst_e'(hburst_i) == HBURST_SINGLE)
                 && (hsize_i <= 3'b010);

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ph_valid <= 1'b0;
            ph_write <= 1'b0;
            ph_addr  <= 4'h0;
        end else if (hready_i) begin
            ph_valid <= sel_ok;
            ph_write <= hwrite_i;
            ph_addr  <= haddr_i[3:0];
        end
    end

    assign data_rd = ph_valid && !ph_write && (ph_addr == `SPI_REG_DATA);
    assign data_wr = ph_valid &&  ph_write && (ph_addr == `SPI_REG_DATA);
    assign ctrl_rd = ph_valid && !ph_write && (ph_addr == `SPI_REG_CTRL);
    assign ctrl_wr = ph_valid &&  ph_write && (ph_addr == `SPI_REG_CTRL);

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state <= PREPARE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            PREPARE: begin
                if (data_rd && rx_q.empty) begin
                    next_state = WAIT_READ;
                end else if (data_wr && tx_q.full) begin
                    next_state = WAIT_WRITE;
                end
            end
            WAIT_READ: begin
                if (!rx_q.empty) begin
                    next_state = PREPARE; // byte arrived
                end
            end
            WAIT_WRITE: begin
                if (!tx_q.full) begin
                    next_state = PREPARE;
                end
            end
            default: next_state = PREPARE;
        endcase
    end

    // data phase ends whenever we land back in PREPARE
    assign hreadyout_o = (next_state == PREPARE);
    assign hresp_o     = 1'b0;

    assign tx_q.wen   = data_wr && !tx_q.full && (state != WAIT_READ);
    assign tx_q.wdata = hwdata_i[7:0];
    assign rx_q.ren   = data_rd && !rx_q.empty && (state != WAIT_WRITE);

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl.raw <= 8'h00;
        end else if (ctrl_wr && (state == PREPARE)) begin
            ctrl.raw <= hwdata_i[7:0];
        end
    end

    assign ctrl_o = ctrl;

    always_comb begin
        hrdata_o = '0;
        if (data_rd && !rx_q.empty) begin
            hrdata_o[7:0] = rx_q.rdata;
        end else if (ctrl_rd) begin
            hrdata_o[7:0] = ctrl.raw;
        end
    end

endmodule

`default_nettype wire

/* hdl/byte_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface byte_fifo_if #(
    parameter int DWIDTH = 8
);
    logic              wen;
    logic [DWIDTH-1:0] wdata;
    logic              ren;
    logic [DWIDTH-1:0] rdata;  // head entry valid in the same cycle as ren
    logic              full;
    logic              empty;

    modport producer (
        output wen,
        output wdata,
        input  full
    );

    modport consumer (
        output ren,
        input  rdata,
        input  empty
    );

    modport fifo (
        input  wen,
        input  wdata,
        input  ren,
        output rdata,
        output full,
        output empty
    );
endinterface

`default_nettype wire

/* hdl/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// AHB bus widths
`define AHB_AWIDTH 32
`define AHB_DWIDTH 32

// entries per byte fifo as a power of two
`define SPI_FIFO_DEPTH 8

// register offsets in the low address nibble
`define SPI_REG_DATA 4'h0
`define SPI_REG_CTRL 4'h4

`endif

/* hdl/spi_pkg.sv */
`default_nettype none

package spi_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HBURST_SINGLE = 3'b000,
        HBURST_INCR   = 3'b001,
        HBURST_WRAP4  = 3'b010,
        HBURST_INCR4  = 3'b011,
        HBURST_WRAP8  = 3'b100,
        HBURST_INCR8  = 3'b101,
        HBURST_WRAP16 = 3'b110,
        HBURST_INCR16 = 3'b111
    } hburst_e;

    // ctrl byte fields from msb down
    typedef struct packed {
        logic [2:0] div;  // half period = div+1 hclk
        logic [1:0] nss;
        logic       cpha;
        logic       cpol;
        logic       en;
    } spi_ctrl_t;

    typedef union packed {
        logic [7:0] raw;
        spi_ctrl_t  f;
    } spi_ctrl_u;

endpackage

`default_nettype wire

/* hdl/spi_shift_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine
    import spi_pkg::*;
(
    input  logic          hclk,
    input  logic          hresetn,
    input  spi_ctrl_u     ctrl_i,

    byte_fifo_if.consumer tx_q,
    byte_fifo_if.producer rx_q,

    input  logic          spi_miso_i,
    output logic          spi_clk_o,
    output logic          spi_mosi_o,
    output logic [1:0]    spi_nss_o
);
    spi_ctrl_t  cfg;

    logic       busy;
    logic       done_r;   // rx byte push cycle after the frame
    logic       start;
    logic       tick;     // one spi clock edge
    logic       last;
    logic       shift_edge;
    logic       clk_ph;
    logic       mosi_r;
    logic [2:0] div_cnt;
    logic [3:0] half_cnt;
    logic [7:0] tx_sh;
    logic [7:0] rx_sh;

    assign cfg = ctrl_i.f;

    // done_r blocks the pop so frames are two idle cycles apart
    assign start = cfg.en && !busy && !done_r && !tx_q.empty;
    assign tick  = busy && (div_cnt >= cfg.div);
    assign last  = (half_cnt == 4'd15);

    // edge number is half_cnt+1
    assign shift_edge = cfg.cpha ? !half_cnt[0] : half_cnt[0];

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            busy     <= 1'b0;
            done_r   <= 1'b0;
            div_cnt  <= 3'd0;
            half_cnt <= 4'd0;
            clk_ph   <= 1'b0;
        end else begin
            done_r <= tick && last;
            if (start) begin
                busy <= 1'b1;
            end else if (tick && last) begin
                busy <= 1'b0;
            end

            if (!busy || tick) begin
                div_cnt <= 3'd0;
            end else begin
                div_cnt <= div_cnt + 3'd1;
            end

            if (start) begin
                half_cnt <= 4'd0;
            end else if (tick) begin
                half_cnt <= half_cnt + 4'd1;
            end

            if (!busy) begin
                clk_ph <= 1'b0;
            end else if (tick) begin
                clk_ph <= !clk_ph; // 16 toggles bring it home
            end
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            tx_sh  <= 8'h00;
            mosi_r <= 1'b0;
        end else if (start) begin
            tx_sh <= tx_q.rdata;
        end else if (tick && shift_edge) begin
            mosi_r <= tx_sh[7];  // cpha 1 drives on the shift edge
            tx_sh  <= {tx_sh[6:0], 1'b0};
        end
    end

    always_ff @(posedge hclk) begin
        if (tick && !shift_edge) begin
            rx_sh <= {rx_sh[6:0], spi_miso_i};
        end
    end

    assign tx_q.ren   = start;
    assign rx_q.wen   = done_r && !rx_q.full; // dropped when full
    assign rx_q.wdata = rx_sh;

    assign spi_clk_o  = cfg.cpol ^ clk_ph;
    assign spi_mosi_o = cfg.cpha ? mosi_r : tx_sh[7];
    assign spi_nss_o  = cfg.en ? cfg.nss : 2'b11;

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int DEPTH  = 8,
    parameter int DWIDTH = 8
)(
    input  logic       hclk,
    input  logic       hresetn,
    byte_fifo_if.fifo  q
);
    localparam int AW = $clog2(DEPTH);

    logic [DWIDTH-1:0] mem [DEPTH];
    logic [AW:0]       wptr;
    logic [AW:0]       rptr;
    logic              push;
    logic              pop;

    assign push = q.wen && !q.full;
    assign pop  = q.ren && !q.empty;

    // extra msb tells a full buffer from an empty one
    assign q.empty = (wptr == rptr);
    assign q.full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
    assign q.rdata = mem[rptr[AW-1:0]];

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (push) begin
            mem[wptr[AW-1:0]] <= q.wdata;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the ahb_spi testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ahb_spi -f sources.f -o sim_ahb_spi
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_ahb_spi 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sources.f */
+incdir+hdl
hdl/spi_pkg.sv
hdl/byte_fifo_if.sv
hdl/sync_fifo.sv
hdl/ahb_spi_regs.sv
hdl/spi_shift_engine.sv
hdl/ahb_spi.sv
dv/ahb_spi_chk.sv
dv/tb_ahb_spi.sv
